// ==== verilog/vid_mon_pkg.sv ====
/*
 * Shared definitions of the video frame monitor
 *   - vertical frame geometry, counted in lines
 *   - colour, accumulator, counter and Wishbone widths
 *   - Wishbone register word addresses
 *   - states of the vertical timing tracker
 */
`default_nettype none

package vid_mon_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned COLOR_W    = 8;
  localparam int unsigned NUM_CHAN   = 3;
  // 600 lines of 255 need 18 bits, two spare
  localparam int unsigned SUM_W      = 20;
  localparam int unsigned LINE_CNT_W = 11;
  localparam int unsigned ERR_CNT_W  = 16;
  localparam int unsigned WB_ADR_W   = 4;
  localparam int unsigned WB_DAT_W   = 32;

  //////////////////////////////////////////////////////////////////////
  // Frame geometry in lines
  //////////////////////////////////////////////////////////////////////

  localparam logic [LINE_CNT_W-1:0] VSYNC_LINES       = 11'd4;
  localparam logic [LINE_CNT_W-1:0] V_BACKPORCH_LINES = 11'd23;
  localparam logic [LINE_CNT_W-1:0] ACT_LINES         = 11'd600;

  //////////////////////////////////////////////////////////////////////
  // Register map, word addresses
  //////////////////////////////////////////////////////////////////////

  localparam logic [WB_ADR_W-1:0] REG_CTRL      = 4'd0;
  localparam logic [WB_ADR_W-1:0] REG_FRAMES    = 4'd1;
  localparam logic [WB_ADR_W-1:0] REG_WIDTH_ERR = 4'd2;
  localparam logic [WB_ADR_W-1:0] REG_SHORT_ERR = 4'd3;
  localparam logic [WB_ADR_W-1:0] REG_LINES     = 4'd4;
  // Red, green, blue follow each base
  localparam logic [WB_ADR_W-1:0] REG_SUM_BASE  = 4'd5;
  localparam logic [WB_ADR_W-1:0] REG_MAX_BASE  = 4'd8;

  // Tracker states
  typedef enum logic [2:0] {
    WAIT_SYNC,
    SYNC,
    BACK_PORCH,
    ACTIVE,
    TAIL
  } vid_state_e;

endpackage

`default_nettype wire

// ==== verilog/vid_stats_if.sv ====
/*
 * Frame statistics from the vertical timing tracker
 * to the register block: frame and error counters,
 * last vsync-to-vsync line total and the frame end strobe
 */
`timescale 1ns/1ps
`default_nettype none

interface vid_stats_if;

  logic [vid_mon_pkg::WB_DAT_W-1:0]   frame_count;
  logic [vid_mon_pkg::ERR_CNT_W-1:0]  width_err_count;
  logic [vid_mon_pkg::ERR_CNT_W-1:0]  short_err_count;
  logic [vid_mon_pkg::LINE_CNT_W-1:0] lines_per_frame;
  // One line wide, after the last active line
  logic                               frame_end;

  modport src (
    output frame_count,
    output width_err_count,
    output short_err_count,
    output lines_per_frame,
    output frame_end
  );

  modport sink (
    input frame_count,
    input width_err_count,
    input short_err_count,
    input lines_per_frame,
    input frame_end
  );

endinterface

`default_nettype wire

// ==== verilog/vid_frame_timing.sv ====
/*
 * Vertical timing tracker of the frame monitor
 *   - vsync phase FSM clocked once per line
 *   - frame start, active line and frame end strobes
 *   - sync width and premature vsync error counters
 *   - frame counter and vsync-to-vsync line total
 */
`timescale 1ns/1ps
`default_nettype none

module vid_frame_timing (
  input  logic        axi2hdmi_hsync_o,
  input  logic        rst_i,
  input  logic        vsync_i,
  input  logic        enable_i,
  input  logic        clear_i,
  output logic        frame_start_o,
  output logic        line_active_o,
  output logic        frame_end_o,
  vid_stats_if.src    stats
);

  vid_mon_pkg::vid_state_e state_q;

  // Lines seen in the current phase
  logic [vid_mon_pkg::LINE_CNT_W-1:0] line_cnt_q;
  // Lines since the last frame start
  logic [vid_mon_pkg::LINE_CNT_W-1:0] frame_lines_q;
  logic [vid_mon_pkg::LINE_CNT_W-1:0] lines_per_frame_q;
  logic [vid_mon_pkg::WB_DAT_W-1:0]   frame_cnt_q;
  logic [vid_mon_pkg::ERR_CNT_W-1:0]  width_err_q;
  logic [vid_mon_pkg::ERR_CNT_W-1:0]  short_err_q;
  logic                               frame_start_q;
  logic                               frame_end_q;

  logic start_frame;
  logic short_vsync;
  logic sync_end;
  logic width_bad;
  logic last_active;
  logic bp_done;

  //////////////////////////////////////////////////////////////////////
  // Line events
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    start_frame = 1'b0;
    short_vsync = 1'b0;
    case (state_q)
      vid_mon_pkg::WAIT_SYNC,
      vid_mon_pkg::TAIL: start_frame = enable_i && vsync_i;
      vid_mon_pkg::BACK_PORCH,
      vid_mon_pkg::ACTIVE: begin
        // Frame cut short, restart on this vsync
        start_frame = enable_i && vsync_i;
        short_vsync = enable_i && vsync_i;
      end
      default: ;
    endcase
  end

  assign sync_end    = enable_i && (state_q == vid_mon_pkg::SYNC) && !vsync_i;
  assign width_bad   = sync_end && (line_cnt_q != vid_mon_pkg::VSYNC_LINES);
  assign bp_done     = (line_cnt_q == vid_mon_pkg::V_BACKPORCH_LINES - 1'b1);
  assign last_active = enable_i && (state_q == vid_mon_pkg::ACTIVE) && !vsync_i &&
                       (line_cnt_q == vid_mon_pkg::ACT_LINES - 1'b1);

  //////////////////////////////////////////////////////////////////////
  // Phase FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (rst_i || !enable_i) begin
      state_q       <= vid_mon_pkg::WAIT_SYNC;
      line_cnt_q    <= '0;
      frame_lines_q <= '0;
      frame_start_q <= 1'b0;
      frame_end_q   <= 1'b0;
    end else begin
      frame_start_q <= start_frame;
      frame_end_q   <= last_active;
      if (frame_lines_q != '1) begin
        frame_lines_q <= frame_lines_q + 1'b1;
      end
      if (start_frame) begin
        state_q       <= vid_mon_pkg::SYNC;
        line_cnt_q    <= 11'd1;
        frame_lines_q <= 11'd1;
      end else begin
        case (state_q)
          vid_mon_pkg::SYNC: begin
            if (!vsync_i) begin
              state_q    <= vid_mon_pkg::BACK_PORCH;
              line_cnt_q <= 11'd1;
            end else if (line_cnt_q != '1) begin
              line_cnt_q <= line_cnt_q + 1'b1;
            end
          end
          vid_mon_pkg::BACK_PORCH: begin
            if (bp_done) begin
              state_q    <= vid_mon_pkg::ACTIVE;
              line_cnt_q <= '0;
            end else begin
              line_cnt_q <= line_cnt_q + 1'b1;
            end
          end
          vid_mon_pkg::ACTIVE: begin
            if (last_active) begin
              state_q <= vid_mon_pkg::TAIL;
            end
            line_cnt_q <= line_cnt_q + 1'b1;
          end
          default: ;
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Counters
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (rst_i || clear_i) begin
      frame_cnt_q       <= '0;
      width_err_q       <= '0;
      short_err_q       <= '0;
      lines_per_frame_q <= '0;
    end else begin
      if (last_active) begin
        frame_cnt_q <= frame_cnt_q + 1'b1;
      end
      if (width_bad && (width_err_q != '1)) begin
        width_err_q <= width_err_q + 1'b1;
      end
      if (short_vsync && (short_err_q != '1)) begin
        short_err_q <= short_err_q + 1'b1;
      end
      // A new vsync closes the previous frame
      if (start_frame && (state_q != vid_mon_pkg::WAIT_SYNC)) begin
        lines_per_frame_q <= frame_lines_q;
      end
    end
  end

  assign frame_start_o = frame_start_q;
  assign frame_end_o   = frame_end_q;
  // Colour is taken on every edge spent in ACTIVE
  assign line_active_o = (state_q == vid_mon_pkg::ACTIVE);

  assign stats.frame_count     = frame_cnt_q;
  assign stats.width_err_count = width_err_q;
  assign stats.short_err_count = short_err_q;
  assign stats.lines_per_frame = lines_per_frame_q;
  assign stats.frame_end       = frame_end_q;

endmodule

`default_nettype wire

// ==== verilog/vid_chan_accum.sv ====
/*
 * One colour channel of the frame monitor: running sum
 * and maximum over the active lines, copied to held
 * outputs at the end of each complete frame
 */
`timescale 1ns/1ps
`default_nettype none

module vid_chan_accum (
  input  logic                             axi2hdmi_hsync_o,
  input  logic                             rst_i,
  input  logic [vid_mon_pkg::COLOR_W-1:0]  color_i,
  input  logic                             frame_start_i,
  input  logic                             line_active_i,
  input  logic                             frame_end_i,
  output logic [vid_mon_pkg::SUM_W-1:0]    sum_o,
  output logic [vid_mon_pkg::COLOR_W-1:0]  max_o
);

  logic [vid_mon_pkg::SUM_W-1:0]   run_sum_q;
  logic [vid_mon_pkg::COLOR_W-1:0] run_max_q;
  logic [vid_mon_pkg::SUM_W-1:0]   color_ext;

  assign color_ext = {{(vid_mon_pkg::SUM_W - vid_mon_pkg::COLOR_W){1'b0}}, color_i};

  // Running values, restarted with every frame
  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (frame_start_i) begin
      run_sum_q <= '0;
      run_max_q <= '0;
    end else if (line_active_i) begin
      run_sum_q <= run_sum_q + color_ext;
      if (color_i > run_max_q) begin
        run_max_q <= color_i;
      end
    end
  end

  // Held results of the last complete frame
  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (rst_i) begin
      sum_o <= '0;
      max_o <= '0;
    end else if (frame_end_i) begin
      sum_o <= run_sum_q;
      max_o <= run_max_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/vid_mon_regs.sv ====
/*
 * Wishbone classic slave of the frame monitor
 *   - single cycle ack, registered read data
 *   - control register with enable and counter clear
 *   - read-only counters, sums and maxima
 *   - frame done strobe
 */
`timescale 1ns/1ps
`default_nettype none

module vid_mon_regs (
  input  logic                                                  axi2hdmi_hsync_o,
  input  logic                                                  rst_i,
  input  logic                                                  wb_cyc_i,
  input  logic                                                  wb_stb_i,
  input  logic                                                  wb_we_i,
  input  logic [vid_mon_pkg::WB_ADR_W-1:0]                      wb_adr_i,
  input  logic [vid_mon_pkg::WB_DAT_W-1:0]                      wb_dat_i,
  output logic [vid_mon_pkg::WB_DAT_W-1:0]                      wb_dat_o,
  output logic                                                  wb_ack_o,
  output logic                                                  enable_o,
  output logic                                                  clear_o,
  output logic                                                  frame_done_o,
  vid_stats_if.sink                                             stats,
  input  logic [vid_mon_pkg::NUM_CHAN-1:0][vid_mon_pkg::SUM_W-1:0]   sum_i,
  input  logic [vid_mon_pkg::NUM_CHAN-1:0][vid_mon_pkg::COLOR_W-1:0] max_i
);

  logic                             ack_q;
  logic                             enable_q;
  logic                             clear_q;
  logic                             done_q;
  logic [vid_mon_pkg::WB_DAT_W-1:0] dat_q;
  logic [vid_mon_pkg::WB_DAT_W-1:0] rdata;
  logic                             wb_req;

  // New request, not the one just answered
  assign wb_req = wb_cyc_i && wb_stb_i && !ack_q;

  //////////////////////////////////////////////////////////////////////
  // Read decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata = '0;
    case (wb_adr_i)
      vid_mon_pkg::REG_CTRL:      rdata[0] = enable_q;
      vid_mon_pkg::REG_FRAMES:    rdata = stats.frame_count;
      vid_mon_pkg::REG_WIDTH_ERR: rdata[vid_mon_pkg::ERR_CNT_W-1:0] = stats.width_err_count;
      vid_mon_pkg::REG_SHORT_ERR: rdata[vid_mon_pkg::ERR_CNT_W-1:0] = stats.short_err_count;
      vid_mon_pkg::REG_LINES:     rdata[vid_mon_pkg::LINE_CNT_W-1:0] = stats.lines_per_frame;
      default: ;
    endcase
    // Channel results, red first
    for (int c = 0; c < vid_mon_pkg::NUM_CHAN; c++) begin
      if (wb_adr_i == vid_mon_pkg::REG_SUM_BASE + c[vid_mon_pkg::WB_ADR_W-1:0]) begin
        rdata[vid_mon_pkg::SUM_W-1:0] = sum_i[c];
      end
      if (wb_adr_i == vid_mon_pkg::REG_MAX_BASE + c[vid_mon_pkg::WB_ADR_W-1:0]) begin
        rdata[vid_mon_pkg::COLOR_W-1:0] = max_i[c];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Ack, control and frame done
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (rst_i) begin
      ack_q    <= 1'b0;
      enable_q <= 1'b0;
      clear_q  <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      ack_q   <= wb_req;
      done_q  <= stats.frame_end;
      // Clear lasts a single line
      clear_q <= 1'b0;
      if (wb_req && wb_we_i && (wb_adr_i == vid_mon_pkg::REG_CTRL)) begin
        enable_q <= wb_dat_i[0];
        clear_q  <= wb_dat_i[1];
      end
    end
  end

  // Read data, valid with ack
  always_ff @(posedge axi2hdmi_hsync_o) begin
    if (wb_req && !wb_we_i) begin
      dat_q <= rdata;
    end
  end

  assign wb_ack_o     = ack_q;
  assign wb_dat_o     = dat_q;
  assign enable_o     = enable_q;
  assign clear_o      = clear_q;
  assign frame_done_o = done_q;

endmodule

`default_nettype wire

// ==== verilog/vid_frame_monitor.sv ====
/*
 * Video frame monitor top level on the HDMI line clock
 *   - vertical timing tracker
 *   - sum and maximum per colour channel
 *   - Wishbone classic register block
 */
`timescale 1ns/1ps
`default_nettype none

module vid_frame_monitor (
  input  logic                                 axi2hdmi_hsync_o,
  input  logic                                 rst_i,
  // Video from the HDMI output
  input  logic                                 axi2hdmi_vsync_o,
  input  logic [vid_mon_pkg::COLOR_W-1:0]      axi2hdmi_red_o,
  input  logic [vid_mon_pkg::COLOR_W-1:0]      axi2hdmi_green_o,
  input  logic [vid_mon_pkg::COLOR_W-1:0]      axi2hdmi_blue_o,
  // Wishbone slave
  input  logic                                 wb_cyc_i,
  input  logic                                 wb_stb_i,
  input  logic                                 wb_we_i,
  input  logic [vid_mon_pkg::WB_ADR_W-1:0]     wb_adr_i,
  input  logic [vid_mon_pkg::WB_DAT_W-1:0]     wb_dat_i,
  output logic [vid_mon_pkg::WB_DAT_W-1:0]     wb_dat_o,
  output logic                                 wb_ack_o,
  output logic                                 frame_done_o
);

  logic [vid_mon_pkg::NUM_CHAN-1:0][vid_mon_pkg::COLOR_W-1:0] color;
  logic [vid_mon_pkg::NUM_CHAN-1:0][vid_mon_pkg::SUM_W-1:0]   sum;
  logic [vid_mon_pkg::NUM_CHAN-1:0][vid_mon_pkg::COLOR_W-1:0] max;

  logic enable;
  logic clear;
  logic frame_start;
  logic line_active;
  logic frame_end;

  vid_stats_if stats_if ();

  // Channel 0 is red
  assign color = {axi2hdmi_blue_o, axi2hdmi_green_o, axi2hdmi_red_o};

  vid_frame_timing timing0 (
    .axi2hdmi_hsync_o ( axi2hdmi_hsync_o ),
    .rst_i            ( rst_i            ),
    .vsync_i          ( axi2hdmi_vsync_o ),
    .enable_i         ( enable           ),
    .clear_i          ( clear            ),
    .frame_start_o    ( frame_start      ),
    .line_active_o    ( line_active      ),
    .frame_end_o      ( frame_end        ),
    .stats            ( stats_if.src     )
  );

  for (genvar c = 0; c < vid_mon_pkg::NUM_CHAN; c++) begin : gen_chan
    vid_chan_accum accum0 (
      .axi2hdmi_hsync_o ( axi2hdmi_hsync_o ),
      .rst_i            ( rst_i            ),
      .color_i          ( color[c]         ),
      .frame_start_i    ( frame_start      ),
      .line_active_i    ( line_active      ),
      .frame_end_i      ( frame_end        ),
      .sum_o            ( sum[c]           ),
      .max_o            ( max[c]           )
    );
  end

  vid_mon_regs regs0 (
    .axi2hdmi_hsync_o ( axi2hdmi_hsync_o ),
    .rst_i            ( rst_i            ),
    .wb_cyc_i         ( wb_cyc_i         ),
    .wb_stb_i         ( wb_stb_i         ),
    .wb_we_i          ( wb_we_i          ),
    .wb_adr_i         ( wb_adr_i         ),
    .wb_dat_i         ( wb_dat_i         ),
    .wb_dat_o         ( wb_dat_o         ),
    .wb_ack_o         ( wb_ack_o         ),
    .enable_o         ( enable           ),
    .clear_o          ( clear            ),
    .frame_done_o     ( frame_done_o     ),
    .stats            ( stats_if.sink    ),
    .sum_i            ( sum              ),
    .max_i            ( max              )
  );

endmodule

`default_nettype wire

// ==== verification/tb_vid_frame_monitor.sv ====
/*
 * Testbench of the video frame monitor
 *   - table of frames applied line by line on the falling edge
 *   - xorshift colour source and reference sums and maxima
 *   - Wishbone classic reads and writes with ack timing checks
 *   - frame done pulse counter and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_vid_frame_monitor;

  localparam int NUM_ROWS = 5;
  // Register checks start this many lines after the vsync of a row
  localparam int CHK_LINE = 60;
  localparam int DISABLED_LOW = 630;
  localparam int EXTRA_LOW = CHK_LINE + 80;

  // Frame table with vsync width, low lines and premature next vsync per row
  int row_vsync [NUM_ROWS] = '{4, 3, 4, 5, 4};
  int row_low   [NUM_ROWS] = '{630, 630, 300, 630, 640};
  bit row_cut   [NUM_ROWS] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0};

  logic        axi2hdmi_hsync_o;
  logic        rst_i;
  logic        axi2hdmi_vsync_o;
  logic [7:0]  axi2hdmi_red_o;
  logic [7:0]  axi2hdmi_green_o;
  logic [7:0]  axi2hdmi_blue_o;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [3:0]  wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic        frame_done_o;

  logic [31:0] rng = 32'd26;
  int          line_no;
  int          done_count;
  int          num_checks;
  int          value_errors;
  int          protocol_errors;

  // Reference model
  int exp_frames;
  int exp_width;
  int exp_short;
  int exp_lines;
  int prev_total;
  bit prev_cut;
  int exp_sum [vid_mon_pkg::NUM_CHAN];
  int exp_max [vid_mon_pkg::NUM_CHAN];
  int run_sum [vid_mon_pkg::NUM_CHAN];
  int run_max [vid_mon_pkg::NUM_CHAN];

  vid_frame_monitor dut0 (
    .axi2hdmi_hsync_o ( axi2hdmi_hsync_o ),
    .rst_i            ( rst_i            ),
    .axi2hdmi_vsync_o ( axi2hdmi_vsync_o ),
    .axi2hdmi_red_o   ( axi2hdmi_red_o   ),
    .axi2hdmi_green_o ( axi2hdmi_green_o ),
    .axi2hdmi_blue_o  ( axi2hdmi_blue_o  ),
    .wb_cyc_i         ( wb_cyc_i         ),
    .wb_stb_i         ( wb_stb_i         ),
    .wb_we_i          ( wb_we_i          ),
    .wb_adr_i         ( wb_adr_i         ),
    .wb_dat_i         ( wb_dat_i         ),
    .wb_dat_o         ( wb_dat_o         ),
    .wb_ack_o         ( wb_ack_o         ),
    .frame_done_o     ( frame_done_o     )
  );

  initial begin
    axi2hdmi_hsync_o = 1'b0;
    forever #20 axi2hdmi_hsync_o = ~axi2hdmi_hsync_o;
  end

  // One count per line with frame done high
  always @(negedge axi2hdmi_hsync_o) begin
    if (!rst_i && frame_done_o === 1'b1) begin
      done_count++;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    num_checks++;
    assert (got === exp) else begin
      value_errors++;
      $display("ERROR %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic wb_access(input logic we, input logic [3:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waited;
    @(negedge axi2hdmi_hsync_o);
    assert (wb_ack_o === 1'b0) else begin
      protocol_errors++;
      $display("Wishbone ack still high before the request to 0x%h", adr);
    end
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdata;
    @(negedge axi2hdmi_hsync_o);
    waited = 1;
    while (wb_ack_o !== 1'b1 && waited < 8) begin
      @(negedge axi2hdmi_hsync_o);
      waited++;
    end
    assert (wb_ack_o === 1'b1) else begin
      protocol_errors++;
      $display("Wishbone access to 0x%h got no ack within 8 cycles", adr);
    end
    assert (waited == 1) else begin
      protocol_errors++;
      $display("Wishbone access to 0x%h acknowledged after %0d cycles", adr, waited);
    end
    rdata    = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic check_reg(input logic [3:0] adr, input logic [31:0] exp,
                           input string name);
    logic [31:0] data;
    wb_access(1'b0, adr, 32'h0, data);
    check_value({"wb_dat_o ", name}, data, exp);
  endtask

  task automatic check_regs(input logic [31:0] exp_ctrl);
    check_reg(vid_mon_pkg::REG_CTRL, exp_ctrl, "REG_CTRL");
    check_reg(vid_mon_pkg::REG_FRAMES, exp_frames, "REG_FRAMES");
    check_reg(vid_mon_pkg::REG_WIDTH_ERR, exp_width, "REG_WIDTH_ERR");
    check_reg(vid_mon_pkg::REG_SHORT_ERR, exp_short, "REG_SHORT_ERR");
    check_reg(vid_mon_pkg::REG_LINES, exp_lines, "REG_LINES");
    for (int c = 0; c < vid_mon_pkg::NUM_CHAN; c++) begin
      check_reg(vid_mon_pkg::REG_SUM_BASE + c, exp_sum[c], $sformatf("REG_SUM %0d", c));
      check_reg(vid_mon_pkg::REG_MAX_BASE + c, exp_max[c], $sformatf("REG_MAX %0d", c));
    end
    check_value("frame_done_o pulses", done_count, exp_frames);
  endtask

  // Drive one vsync period and sum the colours of the active lines
  task automatic drive_lines(input int w, input int low);
    logic [7:0] col [vid_mon_pkg::NUM_CHAN];
    int first_act;
    first_act = w + vid_mon_pkg::V_BACKPORCH_LINES;
    for (int c = 0; c < vid_mon_pkg::NUM_CHAN; c++) begin
      run_sum[c] = 0;
      run_max[c] = 0;
    end
    for (int j = 0; j < w + low; j++) begin
      @(negedge axi2hdmi_hsync_o);
      rng = xorshift32(rng);
      // Two bytes ANDed so that the frame maximum rarely reaches 0xff
      col[0] = rng[7:0] & rng[15:8];
      col[1] = rng[15:8] & rng[23:16];
      col[2] = rng[23:16] & rng[31:24];
      axi2hdmi_vsync_o = (j < w);
      axi2hdmi_red_o   = col[0];
      axi2hdmi_green_o = col[1];
      axi2hdmi_blue_o  = col[2];
      if (j >= first_act && j < first_act + vid_mon_pkg::ACT_LINES) begin
        for (int c = 0; c < vid_mon_pkg::NUM_CHAN; c++) begin
          run_sum[c] += col[c];
          if (col[c] > run_max[c]) begin
            run_max[c] = col[c];
          end
        end
      end
      line_no = j;
    end
  endtask

  task automatic run_row(input int w, input int low, input bit cut);
    // This vsync closes the previous frame
    if (prev_cut) begin
      exp_short++;
    end
    if (prev_total != 0) begin
      exp_lines = prev_total;
    end
    if (w != vid_mon_pkg::VSYNC_LINES) begin
      exp_width++;
    end
    line_no = -1;
    fork
      drive_lines(w, low);
      begin
        wait (line_no >= w + CHK_LINE);
        check_regs(32'h1);
      end
    join
    if (!cut) begin
      exp_frames++;
      for (int c = 0; c < vid_mon_pkg::NUM_CHAN; c++) begin
        exp_sum[c] = run_sum[c];
        exp_max[c] = run_max[c];
      end
    end
    prev_total = w + low;
    prev_cut   = cut;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] wdata_ack;
    rst_i            = 1'b1;
    axi2hdmi_vsync_o = 1'b0;
    axi2hdmi_red_o   = 8'h00;
    axi2hdmi_green_o = 8'h00;
    axi2hdmi_blue_o  = 8'h00;
    wb_cyc_i         = 1'b0;
    wb_stb_i         = 1'b0;
    wb_we_i          = 1'b0;
    wb_adr_i         = 4'h0;
    wb_dat_i         = 32'h0;
    repeat (16) @(negedge axi2hdmi_hsync_o);
    rst_i = 1'b0;
    check_value("wb_ack_o", wb_ack_o, 32'h0);
    check_value("frame_done_o", frame_done_o, 32'h0);
    check_reg(vid_mon_pkg::REG_CTRL, 32'h0, "REG_CTRL");
    // Tracker disabled so nothing may count
    drive_lines(vid_mon_pkg::VSYNC_LINES, DISABLED_LOW);
    check_regs(32'h0);
    wb_access(1'b1, vid_mon_pkg::REG_CTRL, 32'h1, wdata_ack);
    for (int i = 0; i < NUM_ROWS; i++) begin
      run_row(row_vsync[i], row_low[i], row_cut[i]);
    end
    // Extra vsync brings the last frame's line total
    run_row(vid_mon_pkg::VSYNC_LINES, EXTRA_LOW, 1'b1);
    // Counter clear with bit 1 reading back as zero
    wb_access(1'b1, vid_mon_pkg::REG_CTRL, 32'h3, wdata_ack);
    check_reg(vid_mon_pkg::REG_CTRL, 32'h1, "REG_CTRL");
    check_reg(vid_mon_pkg::REG_FRAMES, 32'h0, "REG_FRAMES");
    check_reg(vid_mon_pkg::REG_WIDTH_ERR, 32'h0, "REG_WIDTH_ERR");
    check_reg(vid_mon_pkg::REG_SHORT_ERR, 32'h0, "REG_SHORT_ERR");
    check_reg(vid_mon_pkg::REG_LINES, 32'h0, "REG_LINES");
    $display("Checks %0d, value errors %0d, protocol errors %0d",
             num_checks, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog sized from the frame table
  initial begin
    int unsigned total;
    total = 16 + vid_mon_pkg::VSYNC_LINES + DISABLED_LOW;
    for (int i = 0; i < NUM_ROWS; i++) begin
      total += row_vsync[i] + row_low[i];
    end
    total += vid_mon_pkg::VSYNC_LINES + EXTRA_LOW + 200;
    #(total * 40);
    $display("Watchdog: run did not finish within %0d lines", total);
    $display("Checks %0d, value errors %0d, protocol errors %0d",
             num_checks, value_errors, protocol_errors);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
verilog/vid_mon_pkg.sv
verilog/vid_stats_if.sv
verilog/vid_frame_timing.sv
verilog/vid_chan_accum.sv
verilog/vid_mon_regs.sv
verilog/vid_frame_monitor.sv
verification/tb_vid_frame_monitor.sv
